/* all.f */
design/core_types_pkg.sv
design/gbpt_pkg.sv
design/gbpt_index_hash.sv
design/bram_2rport_1wport.sv
design/gbpt.sv
design/ghr_tracker.sv
design/pred_stats.sv
design/gbpt_unit.sv
sim/gbpt_tb.sv

/* design/bram_2rport_1wport.sv */
// Table RAM with two registered read ports and one full-row write port
`default_nettype none

module bram_2rport_1wport #(
    parameter int INNER_WIDTH = 16,
    parameter int OUTER_WIDTH = 64
) (
    input  logic                           CLK,
    input  logic                           nRST,

    // Read port 0
    input  logic                           port0_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port0_rindex,
    output logic [INNER_WIDTH-1:0]         port0_rdata,

    // Read port 1
    input  logic                           port1_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port1_rindex,
    output logic [INNER_WIDTH-1:0]         port1_rdata,

    // Write port
    input  logic                           wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    // Every counter of a row starts weakly not taken
    localparam logic [INNER_WIDTH-1:0] RESET_ROW = {(INNER_WIDTH / 2){2'(gbpt_pkg::WN)}};

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // ------------------------------
    // Storage
    // ------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < OUTER_WIDTH; i++) begin
                mem[i] <= RESET_ROW;
            end
        end else if (wen_byte) begin
            mem[windex] <= wdata;
        end
    end

    // ------------------------------
    // Registered reads
    // ------------------------------

    // Same-edge write is not forwarded, old row comes out
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            port0_rdata <= RESET_ROW;
            port1_rdata <= RESET_ROW;
        end else begin
            if (port0_ren) begin
                port0_rdata <= mem[port0_rindex];
            end
            if (port1_ren) begin
                port1_rdata <= mem[port1_rindex];
            end
        end
    end

endmodule

`default_nettype wire

/* design/core_types_pkg.sv */
// Core types package with shared vector types for PC, global history and address space ID
`default_nettype none

package core_types_pkg;

    // ------------------------------
    // Fetch and branch addresses
    // ------------------------------

    // Byte address of a fetch or a resolved branch
    typedef logic [31:0] pc_t;

    // ------------------------------
    // Global history
    // ------------------------------

    // Bit 0 holds the newest outcome
    localparam int GH_LENGTH = 12;

    typedef logic [GH_LENGTH-1:0] gh_t;

    // ------------------------------
    // Address space
    // ------------------------------

    localparam int ASID_WIDTH = 9;

    typedef logic [ASID_WIDTH-1:0] asid_t;

endpackage

`default_nettype wire

/* design/gbpt.sv */
// Global branch pattern table with one-cycle lookup and two-stage counter update
`default_nettype none

module gbpt #(
    parameter int GBPT_SETS = 64
) (
    input  logic                  CLK,
    input  logic                  nRST,

    // RESP stage
    input  logic                  valid_RESP,
    input  core_types_pkg::pc_t   full_PC_RESP,
    input  core_types_pkg::gh_t   GH_RESP,
    input  core_types_pkg::asid_t ASID_RESP,

    // RESTART stage
    output logic                  pred_taken_RESTART,

    // Update 0
    input  logic                  update0_valid,
    input  core_types_pkg::pc_t   update0_start_full_PC,
    input  core_types_pkg::gh_t   update0_GH,
    input  core_types_pkg::asid_t update0_ASID,
    input  logic                  update0_taken,

    // Update 1
    output logic                  update1_valid,
    output logic                  update1_correct
);

    localparam int SET_INDEX_WIDTH = $clog2(GBPT_SETS);
    localparam int ENTRY_WIDTH = gbpt_pkg::LOG_GBPT_ENTRIES_PER_BLOCK;
    localparam int INDEX_WIDTH = SET_INDEX_WIDTH + ENTRY_WIDTH;

    typedef logic [SET_INDEX_WIDTH-1:0] set_index_t;
    typedef logic [ENTRY_WIDTH-1:0]     entry_t;

    // RESP and RESTART
    logic [INDEX_WIDTH-1:0] index_RESP;
    set_index_t             set_RESP;
    entry_t                 entry_RESP;
    entry_t                 entry_RESTART;
    gbpt_pkg::gbpt_row_t    row_RESTART;

    // Update 0 and update 1
    logic [INDEX_WIDTH-1:0] update0_index;
    set_index_t             update0_set;
    entry_t                 update0_entry;
    set_index_t             update1_set;
    entry_t                 update1_entry;
    logic                   update1_taken;
    gbpt_pkg::gbpt_row_t    update1_old_row;
    gbpt_pkg::gbpt_row_t    update1_new_row;
    gbpt_pkg::pred_2bc_t    update1_old_2bc;
    gbpt_pkg::pred_2bc_t    update1_new_2bc;

    // ------------------------------
    // RESP stage
    // ------------------------------

    gbpt_index_hash #(
        .GBPT_SETS(GBPT_SETS)
    ) resp_hash (
        .PC   (full_PC_RESP),
        .GH   (GH_RESP),
        .ASID (ASID_RESP),
        .index(index_RESP)
    );

    assign set_RESP   = index_RESP[INDEX_WIDTH-1:ENTRY_WIDTH];
    assign entry_RESP = index_RESP[ENTRY_WIDTH-1:0];

    // ------------------------------
    // RESTART stage
    // ------------------------------

    always_ff @(posedge CLK) begin
        entry_RESTART <= entry_RESP;
    end

    // Upper counter bit of the selected entry
    assign pred_taken_RESTART = row_RESTART[{entry_RESTART, 1'b1}];

    // ------------------------------
    // Update 0
    // ------------------------------

    gbpt_index_hash #(
        .GBPT_SETS(GBPT_SETS)
    ) update_hash (
        .PC   (update0_start_full_PC),
        .GH   (update0_GH),
        .ASID (update0_ASID),
        .index(update0_index)
    );

    assign update0_set   = update0_index[INDEX_WIDTH-1:ENTRY_WIDTH];
    assign update0_entry = update0_index[ENTRY_WIDTH-1:0];

    // ------------------------------
    // Update 1
    // ------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            update1_valid <= 1'b0;
        end else begin
            update1_valid <= update0_valid;
        end
    end

    always_ff @(posedge CLK) begin
        update1_set   <= update0_set;
        update1_entry <= update0_entry;
        update1_taken <= update0_taken;
    end

    assign update1_old_2bc = gbpt_pkg::pred_2bc_t'(update1_old_row[update1_entry*2 +: 2]);

    // Old prediction against the resolved outcome
    assign update1_correct = (update1_old_2bc[1] == update1_taken);

    // Weak states jump straight to the strong state of the outcome
    always_comb begin
        unique case (update1_old_2bc)
            gbpt_pkg::SN: update1_new_2bc = update1_taken ? gbpt_pkg::WN : gbpt_pkg::SN;
            gbpt_pkg::WN: update1_new_2bc = update1_taken ? gbpt_pkg::ST : gbpt_pkg::SN;
            gbpt_pkg::WT: update1_new_2bc = update1_taken ? gbpt_pkg::ST : gbpt_pkg::SN;
            gbpt_pkg::ST: update1_new_2bc = update1_taken ? gbpt_pkg::ST : gbpt_pkg::WT;
            default:      update1_new_2bc = gbpt_pkg::WN;
        endcase
    end

    // Neighbour entries pass through unchanged
    always_comb begin
        update1_new_row = update1_old_row;
        update1_new_row[update1_entry*2 +: 2] = update1_new_2bc;
    end

    // ------------------------------
    // Table storage
    // ------------------------------

    bram_2rport_1wport #(
        .INNER_WIDTH($bits(gbpt_pkg::gbpt_row_t)),
        .OUTER_WIDTH(GBPT_SETS)
    ) table_ram (
        .CLK         (CLK),
        .nRST        (nRST),
        .port0_ren   (valid_RESP),
        .port0_rindex(set_RESP),
        .port0_rdata (row_RESTART),
        .port1_ren   (update0_valid),
        .port1_rindex(update0_set),
        .port1_rdata (update1_old_row),
        .wen_byte    (update1_valid),
        .windex      (update1_set),
        .wdata       (update1_new_row)
    );

endmodule

`default_nettype wire

/* design/gbpt_index_hash.sv */
// Index hash folding PC, global history and ASID into a table set and entry select
`default_nettype none

module gbpt_index_hash #(
    parameter int GBPT_SETS = 64
) (
    input  core_types_pkg::pc_t   PC,
    input  core_types_pkg::gh_t   GH,
    input  core_types_pkg::asid_t ASID,
    output logic [$clog2(GBPT_SETS)+gbpt_pkg::LOG_GBPT_ENTRIES_PER_BLOCK-1:0] index
);

    localparam int INDEX_WIDTH = $clog2(GBPT_SETS) + gbpt_pkg::LOG_GBPT_ENTRIES_PER_BLOCK;

    logic [INDEX_WIDTH-1:0] pc_bits;
    logic [INDEX_WIDTH-1:0] gh_low;
    logic [INDEX_WIDTH-1:0] gh_high;
    logic [INDEX_WIDTH-1:0] asid_bits;

    // Halfword aligned PC, so bit 0 carries no information
    assign pc_bits = PC[INDEX_WIDTH:1];

    // Recent history lines up with the low PC bits
    assign gh_low = GH[INDEX_WIDTH-1:0];

    // Older history folded back onto the bottom
    assign gh_high = INDEX_WIDTH'(GH[core_types_pkg::GH_LENGTH-1:INDEX_WIDTH]);

    // ASID zero-extended or cut to index width
    assign asid_bits = INDEX_WIDTH'(ASID);

    assign index = pc_bits ^ gh_low ^ gh_high ^ asid_bits;

endmodule

`default_nettype wire

/* design/gbpt_pkg.sv */
// Predictor table package with counter encoding and row layout of the pattern table
`default_nettype none

package gbpt_pkg;

    // ------------------------------
    // Two-bit saturating counter
    // ------------------------------

    // Upper bit gives the taken prediction
    typedef enum logic [1:0] {
        SN = 2'b00,
        WN = 2'b01,
        WT = 2'b10,
        ST = 2'b11
    } pred_2bc_t;

    // ------------------------------
    // RAM row layout
    // ------------------------------

    // Counters packed into one RAM row
    localparam int GBPT_ENTRIES_PER_BLOCK = 8;
    localparam int LOG_GBPT_ENTRIES_PER_BLOCK = 3;

    // Entry k sits in bits 2k+1 down to 2k
    typedef logic [GBPT_ENTRIES_PER_BLOCK*2-1:0] gbpt_row_t;

endpackage

`default_nettype wire

/* design/gbpt_unit.sv */
// Branch direction predictor top connecting history tracker, pattern table and statistics
`default_nettype none

module gbpt_unit #(
    parameter int GBPT_SETS  = 64,
    parameter int STAT_WIDTH = 16
) (
    input  logic                  CLK,
    input  logic                  nRST,

    // Lookup
    input  logic                  lookup_valid,
    input  core_types_pkg::pc_t   lookup_pc,
    input  core_types_pkg::asid_t lookup_asid,
    output logic                  pred_valid,
    output logic                  pred_taken,
    output core_types_pkg::gh_t   current_gh,

    // Update
    input  logic                  update_valid,
    input  core_types_pkg::pc_t   update_pc,
    input  core_types_pkg::gh_t   update_gh,
    input  core_types_pkg::asid_t update_asid,
    input  logic                  update_taken,
    output logic                  update_done,
    output logic                  update_correct,

    // Restore
    input  logic                  restore_valid,
    input  core_types_pkg::gh_t   restore_gh,
    input  logic                  restore_taken,

    // Statistics
    output logic [STAT_WIDTH-1:0] stat_updates,
    output logic [STAT_WIDTH-1:0] stat_correct
);

    // History producer
    ghr_tracker history (
        .CLK          (CLK),
        .nRST         (nRST),
        .lookup_valid (lookup_valid),
        .pred_taken   (pred_taken),
        .restore_valid(restore_valid),
        .restore_gh   (restore_gh),
        .restore_taken(restore_taken),
        .pred_valid   (pred_valid),
        .current_gh   (current_gh)
    );

    // Pattern table, lookup hashes with the history of its own cycle
    gbpt #(
        .GBPT_SETS(GBPT_SETS)
    ) table_inst (
        .CLK                  (CLK),
        .nRST                 (nRST),
        .valid_RESP           (lookup_valid),
        .full_PC_RESP         (lookup_pc),
        .GH_RESP              (current_gh),
        .ASID_RESP            (lookup_asid),
        .pred_taken_RESTART   (pred_taken),
        .update0_valid        (update_valid),
        .update0_start_full_PC(update_pc),
        .update0_GH           (update_gh),
        .update0_ASID         (update_asid),
        .update0_taken        (update_taken),
        .update1_valid        (update_done),
        .update1_correct      (update_correct)
    );

    // Statistics consumer
    pred_stats #(
        .STAT_WIDTH(STAT_WIDTH)
    ) stats (
        .CLK           (CLK),
        .nRST          (nRST),
        .update_done   (update_done),
        .update_correct(update_correct),
        .stat_updates  (stat_updates),
        .stat_correct  (stat_correct)
    );

endmodule

`default_nettype wire

/* design/ghr_tracker.sv */
// Speculative global history register, shifted by predictions and reloaded on restore
`default_nettype none

module ghr_tracker (
    input  logic                CLK,
    input  logic                nRST,

    // Lookup side
    input  logic                lookup_valid,
    input  logic                pred_taken,

    // Mispredict restore
    input  logic                restore_valid,
    input  core_types_pkg::gh_t restore_gh,
    input  logic                restore_taken,

    output logic                pred_valid,
    output core_types_pkg::gh_t current_gh
);

    localparam int GH_LENGTH = core_types_pkg::GH_LENGTH;

    // ------------------------------
    // RESTART valid
    // ------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= lookup_valid;
        end
    end

    // ------------------------------
    // History
    // ------------------------------

    // Restore wins over a same-cycle prediction
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            current_gh <= '0;
        end else if (restore_valid) begin
            current_gh <= {restore_gh[GH_LENGTH-2:0], restore_taken};
        end else if (pred_valid) begin
            current_gh <= {current_gh[GH_LENGTH-2:0], pred_taken};
        end
    end

endmodule

`default_nettype wire

/* design/pred_stats.sv */
// Prediction statistics with saturating counts of resolved updates and correct predictions
`default_nettype none

module pred_stats #(
    parameter int STAT_WIDTH = 16
) (
    input  logic                  CLK,
    input  logic                  nRST,

    input  logic                  update_done,
    input  logic                  update_correct,

    output logic [STAT_WIDTH-1:0] stat_updates,
    output logic [STAT_WIDTH-1:0] stat_correct
);

    typedef logic [STAT_WIDTH-1:0] stat_t;

    localparam stat_t STAT_MAX = '1;

    // Every resolved update
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            stat_updates <= '0;
        end else if (update_done && (stat_updates != STAT_MAX)) begin
            stat_updates <= stat_updates + stat_t'(1);
        end
    end

    // Only updates whose old prediction matched
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            stat_correct <= '0;
        end else if (update_done && update_correct && (stat_correct != STAT_MAX)) begin
            stat_correct <= stat_correct + stat_t'(1);
        end
    end

endmodule

`default_nettype wire

/* sim/gbpt_tb.sv */
// Testbench for the branch direction predictor, checked against a model of table, history and stats
`default_nettype none

module gbpt_tb;

    localparam int GBPT_SETS = 64;
    localparam int STAT_WIDTH = 16;
    localparam int IDX_W = $clog2(GBPT_SETS) + gbpt_pkg::LOG_GBPT_ENTRIES_PER_BLOCK;
    localparam int TABLE_SIZE = GBPT_SETS * gbpt_pkg::GBPT_ENTRIES_PER_BLOCK;
    localparam int DRIVE_DELAY = 1;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_UPDATES = 100;
    // Two cycles per update plus the lookup and restore phases
    localparam int TEST_CYCLES = RESET_CYCLES + 2 * RANDOM_UPDATES + 190;
    localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

    typedef logic [IDX_W-1:0] index_t;

    logic CLK, nRST;
    logic lookup_valid, pred_valid, pred_taken;
    core_types_pkg::pc_t lookup_pc, update_pc;
    core_types_pkg::asid_t lookup_asid, update_asid;
    core_types_pkg::gh_t current_gh, update_gh, restore_gh;
    logic update_valid, update_taken, update_done, update_correct;
    logic restore_valid, restore_taken;
    logic [STAT_WIDTH-1:0] stat_updates, stat_correct;

    // Reference model state
    gbpt_pkg::pred_2bc_t model_ctr [TABLE_SIZE];
    core_types_pkg::gh_t model_gh;
    logic exp_pred_valid, exp_pred_taken, exp_update_done, exp_update_correct;
    int model_updates, model_correct;
    int strobe_count;
    int cycle_count = 0;
    integer seed;
    index_t pool [8];

    gbpt_unit #(
        .GBPT_SETS (GBPT_SETS),
        .STAT_WIDTH(STAT_WIDTH)
    ) uut (
        .CLK(CLK), .nRST(nRST),
        .lookup_valid(lookup_valid), .lookup_pc(lookup_pc), .lookup_asid(lookup_asid),
        .pred_valid(pred_valid), .pred_taken(pred_taken), .current_gh(current_gh),
        .update_valid(update_valid), .update_pc(update_pc), .update_gh(update_gh),
        .update_asid(update_asid), .update_taken(update_taken),
        .update_done(update_done), .update_correct(update_correct),
        .restore_valid(restore_valid), .restore_gh(restore_gh), .restore_taken(restore_taken),
        .stat_updates(stat_updates), .stat_correct(stat_correct)
    );

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    // ------------------------------
    // Helpers
    // ------------------------------

    // PC bits W..1 folded with both history halves and the ASID
    function automatic index_t index_of(input core_types_pkg::pc_t pc,
                                        input core_types_pkg::gh_t gh,
                                        input core_types_pkg::asid_t asid);
        index_of = index_t'(pc >> 1) ^ index_t'(gh) ^ index_t'(gh >> IDX_W) ^ index_t'(asid);
    endfunction

    // Inverse of the fold, picks PC bits that land on a chosen entry
    function automatic core_types_pkg::pc_t pc_for_index(input index_t target,
                                                         input core_types_pkg::gh_t gh,
                                                         input core_types_pkg::asid_t asid,
                                                         input core_types_pkg::pc_t upper);
        core_types_pkg::pc_t pc;
        pc = upper;
        pc[IDX_W:1] = target ^ index_t'(gh) ^ index_t'(gh >> IDX_W) ^ index_t'(asid);
        pc_for_index = pc;
    endfunction

    function automatic gbpt_pkg::pred_2bc_t next_counter(input gbpt_pkg::pred_2bc_t old,
                                                         input logic taken);
        if (taken) begin
            next_counter = (old == gbpt_pkg::SN) ? gbpt_pkg::WN : gbpt_pkg::ST;
        end else begin
            next_counter = (old == gbpt_pkg::ST) ? gbpt_pkg::WT : gbpt_pkg::SN;
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] time %0t: %s expected 0x%0h, actual 0x%0h",
                 $time, name, expected, actual);
        $display("Testbench failed");
        $fatal(1, "Value mismatch on %s", name);
    endtask

    task automatic step();
        @(posedge CLK);
        #DRIVE_DELAY;
    endtask

    task automatic do_lookup(input core_types_pkg::pc_t pc, input core_types_pkg::asid_t asid);
        lookup_valid = 1'b1;
        lookup_pc = pc;
        lookup_asid = asid;
        step();
        lookup_valid = 1'b0;
    endtask

    // Idle cycle after each strobe keeps same-set updates two cycles apart
    task automatic do_update(input core_types_pkg::pc_t pc, input core_types_pkg::gh_t gh,
                             input core_types_pkg::asid_t asid, input logic taken);
        update_valid = 1'b1;
        update_pc = pc;
        update_gh = gh;
        update_asid = asid;
        update_taken = taken;
        strobe_count++;
        step();
        update_valid = 1'b0;
        step();
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------

    always @(posedge CLK or negedge nRST) begin : model_step
        core_types_pkg::gh_t next_gh;
        index_t idx;
        if (!nRST) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                model_ctr[i] = gbpt_pkg::WN;
            end
            model_gh = '0;
            {exp_pred_valid, exp_pred_taken, exp_update_done, exp_update_correct} = '0;
            model_updates = 0;
            model_correct = 0;
        end else begin
            // Stats count the update that finished in the last cycle
            if (exp_update_done) begin
                model_updates++;
                model_correct += int'(exp_update_correct);
            end
            next_gh = model_gh;
            if (restore_valid) begin
                next_gh = {restore_gh[core_types_pkg::GH_LENGTH-2:0], restore_taken};
            end else if (exp_pred_valid) begin
                next_gh = {model_gh[core_types_pkg::GH_LENGTH-2:0], exp_pred_taken};
            end
            exp_pred_valid = lookup_valid;
            if (lookup_valid) begin
                exp_pred_taken = model_ctr[index_of(lookup_pc, model_gh, lookup_asid)][1];
            end
            exp_update_done = update_valid;
            if (update_valid) begin
                idx = index_of(update_pc, update_gh, update_asid);
                exp_update_correct = (model_ctr[idx][1] == update_taken);
                model_ctr[idx] = next_counter(model_ctr[idx], update_taken);
            end
            model_gh = next_gh;
        end
    end

    // ------------------------------
    // Checks, sampled mid-cycle
    // ------------------------------

    always @(negedge CLK) begin
        if (nRST) begin
            assert (pred_valid === exp_pred_valid)
                else report_mismatch("pred_valid", 32'(exp_pred_valid), 32'(pred_valid));
            assert (!exp_pred_valid || pred_taken === exp_pred_taken)
                else report_mismatch("pred_taken", 32'(exp_pred_taken), 32'(pred_taken));
            assert (update_done === exp_update_done)
                else report_mismatch("update_done", 32'(exp_update_done), 32'(update_done));
            assert (!exp_update_done || update_correct === exp_update_correct)
                else report_mismatch("update_correct", 32'(exp_update_correct),
                                     32'(update_correct));
            assert (current_gh === model_gh)
                else report_mismatch("current_gh", 32'(model_gh), 32'(current_gh));
            assert (stat_updates === STAT_WIDTH'(model_updates))
                else report_mismatch("stat_updates", 32'(model_updates), 32'(stat_updates));
            assert (stat_correct === STAT_WIDTH'(model_correct))
                else report_mismatch("stat_correct", 32'(model_correct), 32'(stat_correct));
        end
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "Timeout");
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin : stimulus
        index_t target;
        core_types_pkg::gh_t train_gh;
        core_types_pkg::asid_t train_asid;
        core_types_pkg::asid_t asid;
        // Walks WN,T ST,T ST,N WT,T ST,N WT,N SN,N SN,T WN,N from the top bit
        logic [8:0] walk_outcomes;
        seed = 20060;
        walk_outcomes = 9'b110100010;
        nRST = 1'b0;
        {lookup_valid, update_valid, update_taken, restore_valid, restore_taken} = '0;
        lookup_pc = '0;
        lookup_asid = '0;
        update_pc = '0;
        update_gh = '0;
        update_asid = '0;
        restore_gh = '0;
        strobe_count = 0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DELAY;
        nRST = 1'b1;
        step();

        // Fresh table, so WN gives a not-taken prediction
        do_lookup(core_types_pkg::pc_t'($random(seed)), core_types_pkg::asid_t'($random(seed)));
        step();

        target = index_t'($random(seed));
        train_gh = core_types_pkg::gh_t'($random(seed));
        train_asid = core_types_pkg::asid_t'($random(seed));
        for (int i = 8; i >= 0; i--) begin
            do_update(pc_for_index(target, train_gh, train_asid,
                                   core_types_pkg::pc_t'($random(seed))),
                      train_gh, train_asid, walk_outcomes[i]);
        end
        // Neighbour in the same row goes to ST, the walked entry ends at SN
        do_update(pc_for_index(target ^ index_t'(1), train_gh, train_asid, '0),
                  train_gh, train_asid, 1'b1);

        // Whole row, back to back
        for (int e = 0; e < gbpt_pkg::GBPT_ENTRIES_PER_BLOCK; e++) begin
            asid = core_types_pkg::asid_t'($random(seed));
            do_lookup(pc_for_index({target[IDX_W-1:3], 3'(e)}, model_gh, asid,
                                   core_types_pkg::pc_t'($random(seed))), asid);
        end
        step();

        // Random mix over a small pool so counters move and repeat
        for (int i = 0; i < 8; i++) begin
            pool[i] = index_t'($random(seed));
        end
        repeat (RANDOM_UPDATES) begin
            target = pool[3'($random(seed))];
            train_gh = core_types_pkg::gh_t'($random(seed));
            train_asid = core_types_pkg::asid_t'($random(seed));
            do_update(pc_for_index(target, train_gh, train_asid,
                                   core_types_pkg::pc_t'($random(seed))),
                      train_gh, train_asid, 1'($random(seed)));
        end

        // Trained entries, hashed with the moving history
        repeat (40) begin
            asid = core_types_pkg::asid_t'($random(seed));
            do_lookup(pc_for_index(pool[3'($random(seed))], model_gh, asid,
                                   core_types_pkg::pc_t'($random(seed))), asid);
        end

        // Restore lands in the same cycle as pred_valid, sometimes with a new lookup
        for (int i = 0; i < 8; i++) begin
            asid = core_types_pkg::asid_t'($random(seed));
            do_lookup(pc_for_index(pool[3'(i)], model_gh, asid, '0), asid);
            restore_valid = 1'b1;
            restore_gh = core_types_pkg::gh_t'($random(seed));
            restore_taken = 1'($random(seed));
            lookup_valid = i[0];
            lookup_pc = pc_for_index(pool[3'(i + 1)], model_gh, asid, '0);
            step();
            restore_valid = 1'b0;
            lookup_valid = 1'b0;
            step();
        end
        step();

        assert (stat_updates === STAT_WIDTH'(strobe_count)) begin
            $display("Testbench passed");
            $finish;
        end else begin
            report_mismatch("stat_updates", 32'(strobe_count), 32'(stat_updates));
        end
    end

endmodule

`default_nettype wire
